// ==== mbus_pkg.sv ====
package mbus_pkg;

	// field widths
	localparam int prefix_w = 4;
	localparam int fu_id_w = 4;
	localparam int data_w = 32;

	// start bit, address, data and stop bit
	localparam int frame_bits = 42;

	// identity of this node as matched by enumeration frames
	localparam logic [19:0] full_prefix = 20'h12345;
	localparam logic [prefix_w-1:0] bcast_prefix = '0;

	// function ids
	localparam logic [fu_id_w-1:0] fu_enum = 4'hF;
	localparam logic [fu_id_w-1:0] fu_sleep = 4'h1;
	localparam logic [fu_id_w-1:0] fu_layer = 4'h2;
	localparam logic [fu_id_w-1:0] fu_first_user = 4'h4;

	// cycles per power release step
	localparam logic [3:0] wake_delay = 4'd2;

	// bit position within a frame
	typedef logic [$clog2(frame_bits)-1:0] bit_cnt_t;

	typedef struct packed {
		logic [prefix_w-1:0] prefix;
		logic [fu_id_w-1:0] fu_id;
	} mbus_addr_t;

	typedef struct packed {
		mbus_addr_t addr;
		logic [data_w-1:0] data;
	} mbus_msg_t;

	typedef struct packed {
		logic power_on;
		logic release_clk;
		logic release_rst;
		logic release_iso;
	} lc_ctrl_t;

	typedef struct packed {
		logic sleep;
		logic isolate;
		logic reset;
	} pwr_ctrl_t;

endpackage

// ==== mbus_node.sv ====
`timescale 1ns/1ps

module mbus_node
	import mbus_pkg::*;
(
	input  logic clkin,
	input  logic rst,
	input  logic din,
	input  pwr_ctrl_t pwr,
	input  logic tx_req,
	input  mbus_msg_t tx_msg,
	input  logic rx_ack,
	input  logic tx_resp_ack,
	input  logic [prefix_w-1:0] addr_out,
	input  logic addr_valid,
	output logic dout,
	output logic tx_ack,
	output logic tx_succ,
	output logic rx_req,
	output mbus_msg_t rx_msg,
	output logic rx_broadcast,
	output lc_ctrl_t lc,
	output logic sleep_req,
	output logic addr_wr,
	output logic [prefix_w-1:0] addr_in
);

	logic node_rst;
	logic armed;
	bit_cnt_t idle_cnt;
	logic tx_busy;
	bit_cnt_t tx_cnt;
	logic [frame_bits-1:0] tx_shift;
	logic rx_active;
	bit_cnt_t rx_cnt;
	mbus_msg_t rx_shift;
	logic frame_end;
	logic is_bcast;
	logic is_own;
	logic enum_hit;
	logic sleep_hit;
	logic layer_hit;
	logic deliver;

	// held in reset for the whole of sleep and power-up
	assign node_rst = rst | pwr.reset;

	// forward the line unless our own frame is going out
	assign dout = tx_busy ? tx_shift[frame_bits-1] : din;

	assign tx_ack = tx_req & ~tx_busy & ~tx_succ & ~rx_active & armed & din;

	// after power-up the line may be mid-frame, so wait for a full frame of idle
	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			armed <= 1'b1;
			idle_cnt <= '0;
		end
		else if (pwr.reset)
		begin
			armed <= 1'b0;
			idle_cnt <= '0;
		end
		else if (!armed)
		begin
			if (!din)
				idle_cnt <= '0;
			else if (idle_cnt == bit_cnt_t'(frame_bits - 1))
				armed <= 1'b1;
			else
				idle_cnt <= idle_cnt + 1'b1;
		end
	end

	// transmit start bit, message and stop bit MSB first
	always_ff @(posedge clkin)
	begin
		if (node_rst)
		begin
			tx_busy <= 1'b0;
			tx_succ <= 1'b0;
			tx_cnt <= '0;
		end
		else if (tx_ack)
		begin
			tx_busy <= 1'b1;
			tx_cnt <= '0;
		end
		else if (tx_busy)
		begin
			if (tx_cnt == bit_cnt_t'(frame_bits - 1))
			begin
				tx_busy <= 1'b0;
				tx_succ <= 1'b1;
			end
			else
				tx_cnt <= tx_cnt + 1'b1;
		end
		else if (tx_succ && tx_resp_ack)
			tx_succ <= 1'b0;
	end

	always_ff @(posedge clkin)
	begin
		if (tx_ack)
			tx_shift <= {1'b0, tx_msg, 1'b1};
		else if (tx_busy)
			tx_shift <= {tx_shift[frame_bits-2:0], 1'b1};
	end

	// receive finds the start bit and then shifts in address and data
	always_ff @(posedge clkin)
	begin
		if (node_rst)
		begin
			rx_active <= 1'b0;
			rx_cnt <= '0;
		end
		else if (!rx_active)
		begin
			if (armed && !tx_busy && !din)
			begin
				rx_active <= 1'b1;
				rx_cnt <= '0;
			end
		end
		else if (rx_cnt == bit_cnt_t'($bits(mbus_msg_t)))
			rx_active <= 1'b0;
		else
			rx_cnt <= rx_cnt + 1'b1;
	end

	always_ff @(posedge clkin)
	begin
		if (rx_active && rx_cnt != bit_cnt_t'($bits(mbus_msg_t)))
			rx_shift <= {rx_shift[$bits(mbus_msg_t)-2:0], din};
	end

	// stop bit must be high or the frame is dropped
	assign frame_end = rx_active && (rx_cnt == bit_cnt_t'($bits(mbus_msg_t))) && din;

	// address decode
	assign is_bcast = (rx_shift.addr.prefix == bcast_prefix);
	assign is_own = addr_valid && (rx_shift.addr.prefix == addr_out);
	assign enum_hit = is_bcast && (rx_shift.addr.fu_id == fu_enum)
		&& (rx_shift.data[prefix_w +: $bits(full_prefix)] == full_prefix)
		&& (rx_shift.data[prefix_w-1:0] != '0);
	assign sleep_hit = is_own && (rx_shift.addr.fu_id == fu_sleep);
	assign layer_hit = is_own && (rx_shift.addr.fu_id == fu_layer);
	assign deliver = (is_own && (rx_shift.addr.fu_id >= fu_first_user))
		|| (is_bcast && (rx_shift.addr.fu_id != fu_enum));

	always_ff @(posedge clkin)
	begin
		if (node_rst)
		begin
			rx_req <= 1'b0;
			sleep_req <= 1'b0;
			addr_wr <= 1'b0;
			lc <= '0;
		end
		else
		begin
			sleep_req <= frame_end && sleep_hit;
			addr_wr <= frame_end && enum_hit;
			if (frame_end && layer_hit)
				lc <= lc_ctrl_t'(rx_shift.data[$bits(lc_ctrl_t)-1:0]);
			// a frame arriving while one is still pending is not delivered
			if (rx_req)
			begin
				if (rx_ack)
					rx_req <= 1'b0;
			end
			else if (frame_end && deliver)
				rx_req <= 1'b1;
		end
	end

	always_ff @(posedge clkin)
	begin
		if (frame_end && enum_hit)
			addr_in <= rx_shift.data[prefix_w-1:0];
		if (frame_end && deliver && !rx_req)
		begin
			rx_msg <= rx_shift;
			rx_broadcast <= is_bcast;
		end
	end

endmodule

// ==== mbus_sleep_ctrl.sv ====
`timescale 1ns/1ps

module mbus_sleep_ctrl
	import mbus_pkg::*;
(
	input  logic clkin,
	input  logic rst,
	input  logic din,
	input  logic sleep_req,
	input  logic int_pend,
	output pwr_ctrl_t pwr,
	output logic clr_busy
);

	typedef enum logic [2:0] {
		st_awake,
		st_isolating,
		st_asleep,
		st_powering,
		st_releasing
	} state_t;

	state_t state;
	logic [$bits(wake_delay)-1:0] wait_cnt;

	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			state <= st_awake;
			pwr <= '0;
			wait_cnt <= '0;
			clr_busy <= 1'b0;
		end
		else
		begin
			clr_busy <= 1'b0;
			case (state)
				st_awake:
					if (sleep_req)
					begin
						pwr.isolate <= 1'b1;
						state <= st_isolating;
					end
				st_isolating:
				begin
					pwr.sleep <= 1'b1;
					pwr.reset <= 1'b1;
					state <= st_asleep;
				end
				// start bit on the line or a pending interrupt
				st_asleep:
					if (!din || int_pend)
					begin
						pwr.sleep <= 1'b0;
						wait_cnt <= '0;
						state <= st_powering;
					end
				st_powering:
					if (wait_cnt == wake_delay - 1'b1)
					begin
						pwr.reset <= 1'b0;
						wait_cnt <= '0;
						state <= st_releasing;
					end
					else
						wait_cnt <= wait_cnt + 1'b1;
				st_releasing:
					if (wait_cnt == wake_delay - 1'b1)
					begin
						pwr.isolate <= 1'b0;
						clr_busy <= 1'b1;
						state <= st_awake;
					end
					else
						wait_cnt <= wait_cnt + 1'b1;
				default:
					state <= st_awake;
			endcase
		end
	end

endmodule

// ==== mbus_isolation.sv ====
`timescale 1ns/1ps

module mbus_isolation
	import mbus_pkg::*;
(
	input  logic isolate,
	// from the node
	input  logic tx_ack_n,
	input  logic tx_succ_n,
	input  logic rx_req_n,
	input  lc_ctrl_t lc_n,
	// from the layer
	input  logic tx_req,
	input  logic rx_ack,
	input  logic tx_resp_ack,
	// to the layer
	output logic tx_ack,
	output logic tx_succ,
	output logic rx_req,
	output lc_ctrl_t lc,
	// to the node
	output logic tx_req_n,
	output logic rx_ack_n,
	output logic tx_resp_ack_n
);

	// node side held low while it is unpowered
	assign tx_ack = tx_ack_n & ~isolate;
	assign tx_succ = tx_succ_n & ~isolate;
	assign rx_req = rx_req_n & ~isolate;
	assign lc = isolate ? lc_ctrl_t'('0) : lc_n;

	// layer inputs are garbage until the layer has power
	assign tx_req_n = tx_req & lc.power_on;
	assign rx_ack_n = rx_ack & lc.power_on;
	assign tx_resp_ack_n = tx_resp_ack & lc.power_on;

endmodule

// ==== mbus_wire_ctrl.sv ====
`timescale 1ns/1ps

module mbus_wire_ctrl
(
	input  logic clkin,
	input  logic rst,
	input  logic din,
	input  logic node_dout,
	input  logic isolate,
	output logic dout
);

	// bypass the node while it is isolated
	always_ff @(posedge clkin)
	begin
		if (rst)
			dout <= 1'b1;
		else if (isolate)
			dout <= din;
		else
			dout <= node_dout;
	end

endmodule

// ==== mbus_addr_rf.sv ====
`timescale 1ns/1ps

module mbus_addr_rf
	import mbus_pkg::*;
(
	input  logic clkin,
	input  logic rst,
	input  logic addr_wr,
	input  logic [prefix_w-1:0] addr_in,
	output logic [prefix_w-1:0] addr_out,
	output logic addr_valid
);

	// always on, so the prefix survives sleep
	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			addr_out <= '0;
			addr_valid <= 1'b0;
		end
		else if (addr_wr)
		begin
			addr_out <= addr_in;
			addr_valid <= 1'b1;
		end
	end

endmodule

// ==== mbus_int_ctrl.sv ====
`timescale 1ns/1ps

module mbus_int_ctrl
(
	input  logic clkin,
	input  logic rst,
	input  logic req_int,
	input  logic sleep,
	input  logic clr_busy,
	output logic int_pend
);

	logic req_int_d;

	always_ff @(posedge clkin)
	begin
		if (rst)
		begin
			req_int_d <= 1'b0;
			int_pend <= 1'b0;
		end
		else
		begin
			req_int_d <= req_int;
			// held until the wake sequence finishes
			if (clr_busy)
				int_pend <= 1'b0;
			else if (sleep && req_int && !req_int_d)
				int_pend <= 1'b1;
		end
	end

endmodule

// ==== mbus_layer_wrapper.sv ====
`timescale 1ns/1ps

module mbus_layer_wrapper
	import mbus_pkg::*;
(
	input  logic clkin,
	input  logic rst,
	input  logic din,
	output logic dout,
	input  mbus_msg_t tx_msg,
	input  logic tx_req,
	output logic tx_ack,
	output logic tx_succ,
	input  logic tx_resp_ack,
	output mbus_msg_t rx_msg,
	output logic rx_req,
	input  logic rx_ack,
	output logic rx_broadcast,
	output logic lc_power_on,
	output logic lc_release_clk,
	output logic lc_release_rst,
	output logic lc_release_iso,
	input  logic req_int
);

	pwr_ctrl_t pwr;
	logic sleep_req;
	logic clr_busy;
	logic int_pend;
	logic node_dout;

	// node side of the isolation block
	logic tx_ack_n;
	logic tx_succ_n;
	logic rx_req_n;
	lc_ctrl_t lc_n;
	logic tx_req_n;
	logic rx_ack_n;
	logic tx_resp_ack_n;
	lc_ctrl_t lc;

	logic addr_wr;
	logic [prefix_w-1:0] addr_in;
	logic [prefix_w-1:0] addr_out;
	logic addr_valid;

	// power gated bus controller
	mbus_node n0 (
		.clkin       (clkin),
		.rst         (rst),
		.din         (din),
		.pwr         (pwr),
		.tx_req      (tx_req_n),
		.tx_msg      (tx_msg),
		.rx_ack      (rx_ack_n),
		.tx_resp_ack (tx_resp_ack_n),
		.addr_out    (addr_out),
		.addr_valid  (addr_valid),
		.dout        (node_dout),
		.tx_ack      (tx_ack_n),
		.tx_succ     (tx_succ_n),
		.rx_req      (rx_req_n),
		.rx_msg      (rx_msg),
		.rx_broadcast(rx_broadcast),
		.lc          (lc_n),
		.sleep_req   (sleep_req),
		.addr_wr     (addr_wr),
		.addr_in     (addr_in)
	);

	// always on blocks
	mbus_sleep_ctrl sc0 (
		.clkin    (clkin),
		.rst      (rst),
		.din      (din),
		.sleep_req(sleep_req),
		.int_pend (int_pend),
		.pwr      (pwr),
		.clr_busy (clr_busy)
	);

	mbus_isolation iso0 (
		.isolate      (pwr.isolate),
		.tx_ack_n     (tx_ack_n),
		.tx_succ_n    (tx_succ_n),
		.rx_req_n     (rx_req_n),
		.lc_n         (lc_n),
		.tx_req       (tx_req),
		.rx_ack       (rx_ack),
		.tx_resp_ack  (tx_resp_ack),
		.tx_ack       (tx_ack),
		.tx_succ      (tx_succ),
		.rx_req       (rx_req),
		.lc           (lc),
		.tx_req_n     (tx_req_n),
		.rx_ack_n     (rx_ack_n),
		.tx_resp_ack_n(tx_resp_ack_n)
	);

	mbus_wire_ctrl wc0 (
		.clkin    (clkin),
		.rst      (rst),
		.din      (din),
		.node_dout(node_dout),
		.isolate  (pwr.isolate),
		.dout     (dout)
	);

	mbus_addr_rf rf0 (
		.clkin     (clkin),
		.rst       (rst),
		.addr_wr   (addr_wr),
		.addr_in   (addr_in),
		.addr_out  (addr_out),
		.addr_valid(addr_valid)
	);

	mbus_int_ctrl mic0 (
		.clkin   (clkin),
		.rst     (rst),
		.req_int (req_int),
		.sleep   (pwr.sleep),
		.clr_busy(clr_busy),
		.int_pend(int_pend)
	);

	assign lc_power_on = lc.power_on;
	assign lc_release_clk = lc.release_clk;
	assign lc_release_rst = lc.release_rst;
	assign lc_release_iso = lc.release_iso;

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic clk,
	output logic rst
);

	// 8 ns period
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// reset held for two rising edges
	initial
	begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== mbus_layer_wrapper_tb.sv ====
`timescale 1ns/1ps

module mbus_layer_wrapper_tb
	import mbus_pkg::*;
;

	typedef logic [frame_bits-1:0] frame_t;

	typedef struct packed {
		logic awake;
		logic valid;
		logic [prefix_w-1:0] prefix;
		lc_ctrl_t lc;
		logic pending;
	} model_t;

	typedef struct packed {
		model_t next;
		logic deliver;
		logic bcast;
		frame_t fwd;
	} ref_t;

	localparam int num_frames = 18;
	localparam int cycle_limit = 60 * num_frames + 200;

	logic clk;
	logic rst;
	logic din;
	logic dout;
	mbus_msg_t tx_msg;
	logic tx_req;
	logic tx_ack;
	logic tx_succ;
	logic tx_resp_ack;
	mbus_msg_t rx_msg;
	logic rx_req;
	logic rx_ack;
	logic rx_broadcast;
	logic lc_power_on;
	logic lc_release_clk;
	logic lc_release_rst;
	logic lc_release_iso;
	logic req_int;
	lc_ctrl_t lc_seen;

	int cyc = 0;
	int ack_cyc = -1;
	logic cap_on = 1'b0;
	int cap_n;
	int cap_start;
	frame_t cap_frame;
	frame_t out_q[$];
	int out_start_q[$];
	model_t model;
	int errors = 0;

	tb_clock_gen clk_gen (
		.clk(clk),
		.rst(rst)
	);

	mbus_layer_wrapper mbus_layer_wrapper_inst (
		.clkin         (clk),
		.rst           (rst),
		.din           (din),
		.dout          (dout),
		.tx_msg        (tx_msg),
		.tx_req        (tx_req),
		.tx_ack        (tx_ack),
		.tx_succ       (tx_succ),
		.tx_resp_ack   (tx_resp_ack),
		.rx_msg        (rx_msg),
		.rx_req        (rx_req),
		.rx_ack        (rx_ack),
		.rx_broadcast  (rx_broadcast),
		.lc_power_on   (lc_power_on),
		.lc_release_clk(lc_release_clk),
		.lc_release_rst(lc_release_rst),
		.lc_release_iso(lc_release_iso),
		.req_int       (req_int)
	);

	assign lc_seen = {lc_power_on, lc_release_clk, lc_release_rst, lc_release_iso};

	task automatic fail_now();
		errors++;
		$display("Something failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_msg(input string name, input mbus_msg_t exp, input mbus_msg_t act);
		if (act !== exp)
		begin
			$display("mismatch %s: expected %h actual %h", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_lc(input string name, input lc_ctrl_t exp, input lc_ctrl_t act);
		if (act !== exp)
		begin
			$display("mismatch %s lc: expected %b actual %b", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("mismatch %s: expected %b actual %b", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_frame(input string name, input frame_t exp, input frame_t act);
		if (act !== exp)
		begin
			$display("mismatch %s frame: expected %h actual %h", name, exp, act);
			fail_now();
		end
	endtask

	task automatic check_int(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("mismatch %s cycle: expected %0d actual %0d", name, exp, act);
			fail_now();
		end
	endtask

	// expected node behavior for one frame on din
	function automatic ref_t ref_decode(input model_t m, input mbus_msg_t msg);
		ref_t r;
		logic is_b;
		logic is_own;
		r.next = m;
		r.deliver = 1'b0;
		r.bcast = 1'b0;
		r.fwd = {1'b0, msg, 1'b1};
		is_b = (msg.addr.prefix == 4'h0);
		is_own = m.valid && (msg.addr.prefix == m.prefix);
		if (!m.awake)
			// the start bit wakes the node but the frame itself is lost
			r.next.awake = 1'b1;
		else
		begin
			if (is_b && msg.addr.fu_id == 4'hF && msg.data[23:4] == 20'h12345
				&& msg.data[3:0] != 4'h0)
			begin
				r.next.prefix = msg.data[3:0];
				r.next.valid = 1'b1;
			end
			if (is_own && msg.addr.fu_id == 4'h1)
			begin
				r.next.awake = 1'b0;
				r.next.lc = '0;
				r.next.pending = 1'b0;
			end
			if (is_own && msg.addr.fu_id == 4'h2)
				r.next.lc = msg.data[3:0];
			r.deliver = ((is_own && msg.addr.fu_id >= 4'h4) || (is_b && msg.addr.fu_id != 4'hF))
				&& !m.pending;
			if (r.deliver)
			begin
				r.next.pending = 1'b1;
				r.bcast = is_b;
			end
		end
		return r;
	endfunction

	function automatic mbus_msg_t make_msg(input logic [3:0] prefix, input logic [3:0] fu,
		input logic [31:0] data);
		mbus_msg_t m;
		m.addr.prefix = prefix;
		m.addr.fu_id = fu;
		m.data = data;
		return m;
	endfunction

	// frame capture on dout with cycle count and watchdog
	always @(posedge clk)
	begin
		if (!rst)
		begin
			cyc = cyc + 1;
			if (cyc > cycle_limit)
			begin
				$display("timeout: test did not finish within %0d cycles", cycle_limit);
				fail_now();
			end
			if (tx_ack)
				ack_cyc = cyc;
			if (cap_on)
			begin
				cap_frame = {cap_frame[frame_bits-2:0], dout};
				cap_n++;
				if (cap_n == frame_bits)
				begin
					out_q.push_back(cap_frame);
					out_start_q.push_back(cap_start);
					cap_on = 1'b0;
				end
			end
			else if (dout == 1'b0)
			begin
				cap_on = 1'b1;
				cap_n = 1;
				cap_frame = '0;
				cap_start = cyc;
			end
		end
	end

	task automatic send_frame(input mbus_msg_t msg, output int start);
		frame_t f;
		f = {1'b0, msg, 1'b1};
		for (int i = frame_bits - 1; i >= 0; i--)
		begin
			@(negedge clk);
			din = f[i];
			if (i == frame_bits - 1)
				start = cyc + 1;
		end
		@(negedge clk);
		din = 1'b1;
	endtask

	task automatic get_frame(output frame_t f, output int start);
		int waited;
		waited = 0;
		while (out_q.size() == 0)
		begin
			if (waited == 60)
			begin
				$display("no frame appeared on dout");
				fail_now();
			end
			@(negedge clk);
			waited++;
		end
		f = out_q.pop_front();
		start = out_start_q.pop_front();
	endtask

	task automatic ack_rx(input string name);
		@(negedge clk);
		rx_ack = 1'b1;
		@(negedge clk);
		rx_ack = 1'b0;
		check_bit({name, " rx_req after ack"}, 1'b0, rx_req);
		model.pending = 1'b0;
	endtask

	task automatic run_frame(input string name, input mbus_msg_t msg);
		ref_t r;
		frame_t got;
		int sent;
		int seen;
		int n;
		r = ref_decode(model, msg);
		send_frame(msg, sent);
		get_frame(got, seen);
		check_frame(name, r.fwd, got);
		// pass-through is one register
		check_int(name, sent + 1, seen);
		if (r.deliver)
		begin
			n = 0;
			while (!rx_req)
			begin
				if (n == 4)
				begin
					$display("%s: rx_req did not rise for a delivered frame", name);
					fail_now();
				end
				@(negedge clk);
				n++;
			end
			check_msg(name, msg, rx_msg);
			check_bit({name, " broadcast"}, r.bcast, rx_broadcast);
		end
		else
		begin
			repeat (3) @(negedge clk);
			check_bit({name, " rx_req"}, r.next.pending, rx_req);
		end
		check_lc(name, r.next.lc, lc_seen);
		model = r.next;
		if (model.pending && model.lc.power_on)
			ack_rx(name);
	endtask

	initial
	begin
		logic [3:0] new_pfx;
		logic [3:0] other_pfx;
		logic [3:0] fu;
		int n;
		frame_t got;
		int seen;
		din = 1'b1;
		tx_req = 1'b0;
		tx_msg = '0;
		rx_ack = 1'b0;
		tx_resp_ack = 1'b0;
		req_int = 1'b0;
		model = '0;
		model.awake = 1'b1;
		void'($urandom(32'h391f33e4));
		wait (!rst);
		@(negedge clk);
		check_bit("reset dout", 1'b1, dout);
		check_bit("reset rx_req", 1'b0, rx_req);
		check_bit("reset tx_succ", 1'b0, tx_succ);
		check_lc("reset", '0, lc_seen);

		// unpowered layer gets no ack
		tx_req = 1'b1;
		tx_msg = make_msg(4'($urandom), 4'($urandom), $urandom);
		repeat (8)
		begin
			@(negedge clk);
			check_bit("unpowered tx_ack", 1'b0, tx_ack);
		end
		tx_req = 1'b0;

		new_pfx = 4'(1 + $urandom % 15);
		other_pfx = 4'((int'(new_pfx) % 15) + 1);
		run_frame("enum match", make_msg(4'h0, 4'hF, {8'($urandom), 20'h12345, new_pfx}));
		run_frame("enum no match", make_msg(4'h0, 4'hF, {8'h00, 20'h54321, other_pfx}));
		run_frame("layer on", make_msg(new_pfx, 4'h2, {28'($urandom), 1'b1, 3'($urandom)}));
		run_frame("deliver", make_msg(new_pfx, 4'(4 + $urandom % 12), $urandom));
		run_frame("other prefix", make_msg(other_pfx, 4'(4 + $urandom % 12), $urandom));

		// transmit
		tx_msg = make_msg(4'($urandom), 4'($urandom), $urandom);
		ack_cyc = -1;
		tx_req = 1'b1;
		n = 0;
		while (ack_cyc < 0)
		begin
			if (n == 10)
			begin
				$display("tx_ack never came for a powered layer");
				fail_now();
			end
			@(negedge clk);
			n++;
		end
		tx_req = 1'b0;
		get_frame(got, seen);
		check_frame("transmit", {1'b0, tx_msg, 1'b1}, got);
		check_int("transmit start", ack_cyc + 2, seen);
		repeat (3)
		begin
			check_bit("tx_succ held", 1'b1, tx_succ);
			@(negedge clk);
		end
		tx_resp_ack = 1'b1;
		@(negedge clk);
		tx_resp_ack = 1'b0;
		check_bit("tx_succ cleared", 1'b0, tx_succ);

		// mixed own, broadcast and foreign traffic
		for (int i = 0; i < 6; i++)
		begin
			case (i % 3)
				0: run_frame("fwd own", make_msg(new_pfx, 4'(4 + $urandom % 12), $urandom));
				1: run_frame("fwd bcast", make_msg(4'h0, 4'($urandom % 15), $urandom));
				default: run_frame("fwd other", make_msg(other_pfx, 4'($urandom), $urandom));
			endcase
		end

		// sleep, then wake on a start bit
		run_frame("sleep", make_msg(new_pfx, 4'h1, $urandom));
		run_frame("wake frame", make_msg(new_pfx, 4'(4 + $urandom % 12), $urandom));
		repeat (50) @(negedge clk);
		run_frame("after wake", make_msg(new_pfx, 4'(4 + $urandom % 12), $urandom));
		run_frame("layer on again", make_msg(new_pfx, 4'h2, {28'($urandom), 4'hF}));

		// sleep, then wake on an interrupt
		run_frame("sleep again", make_msg(new_pfx, 4'h1, $urandom));
		@(negedge clk);
		req_int = 1'b1;
		@(negedge clk);
		req_int = 1'b0;
		model.awake = 1'b1;
		repeat (55) @(negedge clk);
		fu = 4'(4 + $urandom % 12);
		run_frame("after interrupt", make_msg(new_pfx, fu, $urandom));

		if (errors == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("Something failed");
			$fatal(1, "errors were found");
		end
	end

endmodule

// ==== vlog.f ====
mbus_pkg.sv
mbus_node.sv
mbus_sleep_ctrl.sv
mbus_isolation.sv
mbus_wire_ctrl.sv
mbus_addr_rf.sv
mbus_int_ctrl.sv
mbus_layer_wrapper.sv
tb_clock_gen.sv
mbus_layer_wrapper_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run; pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module mbus_layer_wrapper_tb -o sim \
	&& ./obj_dir/sim | tee /dev/stderr | grep -q "Everything OK" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
